// ==== list.f ====
design/xb_cfg_pkg.sv
design/xb_stream_pkg.sv
design/setting_reg.sv
design/axi_fifo_short.sv
design/pkt_monitor.sv
design/axi_crossbar.sv
design/xb_subsystem_top.sv
tests/xb_checker.sv
tests/xb_tb.sv

// ==== Makefile ====
# Verilator build and run for the packet switch testbench

VERILATOR ?= verilator
TOP       ?= xb_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/xb_tb.sv ====
// ----------------------------------------
// Testbench for the packet switch
// Random packets, reference routing and a scoreboard
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module xb_tb;

   import xb_cfg_pkg::*;

   localparam int NUM_IN          = 2;
   localparam int NUM_OUT         = 3;
   localparam int CLK_PERIOD      = 40;
   localparam int MAX_LEN         = 8;
   localparam int N_OPEN          = 24;
   localparam int N_HELD          = 4;
   localparam int N_SIDE          = 6;
   localparam int N_AFTER         = 16;
   localparam int TOTAL_WORDS     = (N_OPEN + N_HELD + N_SIDE + N_AFTER) * MAX_LEN;
   localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 12 + 100;

   logic                  clk;
   logic                  arst_n;
   logic                  clear;
   logic                  set_stb;
   logic [SR_AWIDTH-1:0]  set_addr;
   logic [SR_DWIDTH-1:0]  set_data;
   logic [NUM_IN*64-1:0]  in_tdata;
   logic [NUM_IN-1:0]     in_tvalid;
   logic [NUM_IN-1:0]     in_tlast;
   logic [NUM_IN-1:0]     in_tready;
   logic [NUM_OUT*64-1:0] out_tdata;
   logic [NUM_OUT-1:0]    out_tvalid;
   logic [NUM_OUT-1:0]    out_tlast;
   logic [NUM_OUT-1:0]    out_tready;

   // Words are {last, data}
   logic [64:0]           drv_q [NUM_IN][$];
   logic [64:0]           exp_q [NUM_OUT][NUM_IN][$];
   int                    rd_idx [NUM_OUT][NUM_IN];
   logic [15:0]           seq_num [NUM_IN];
   int                    burst_left [NUM_OUT];
   logic                  ready_state [NUM_OUT];
   logic [NUM_OUT-1:0]    hold_low;
   logic [7:0]            exp_local;
   integer                seed;

   xb_subsystem_top #(
      .NUM_INPUTS  (NUM_IN),
      .NUM_OUTPUTS (NUM_OUT)
   ) i_xb_subsystem_top (
      .i_clk      (clk),
      .i_arst_n   (arst_n),
      .i_clear    (clear),
      .i_set_stb  (set_stb),
      .i_set_addr (set_addr),
      .i_set_data (set_data),
      .i_tdata    (in_tdata),
      .i_tvalid   (in_tvalid),
      .i_tlast    (in_tlast),
      .o_tready   (in_tready),
      .o_tdata    (out_tdata),
      .o_tvalid   (out_tvalid),
      .o_tlast    (out_tlast),
      .i_tready   (out_tready)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // Expected output for a header under a given local address
   function automatic int route_of(input logic [63:0] hdr, input logic [7:0] local_addr);
      logic [15:0] dst;
      dst = hdr[63:48];
      if (dst[15:8] == local_addr) begin
         return int'(dst[7:0]) % NUM_OUT;
      end
      return NUM_OUT - 1;
   endfunction

   function automatic logic [15:0] dst_for(input int out, input logic [5:0] spread);
      return {exp_local, 8'(out + 3 * int'(spread))};
   endfunction

   task automatic make_packet(input int src, input logic [15:0] dst, input int len);
      logic [63:0] word;
      int          dest;
      word = {dst, 16'(src), seq_num[src], 16'(len)};
      dest = route_of(word, exp_local);
      seq_num[src] = seq_num[src] + 16'd1;
      for (int k = 0; k < len; k++) begin
         if (k > 0) begin
            word = {$random(seed), $random(seed)};
         end
         drv_q[src].push_back({(k == len - 1), word});
         exp_q[dest][src].push_back({(k == len - 1), word});
      end
   endtask

   // About half the packets hit the local address
   task automatic random_packet(input int src);
      logic [31:0] r;
      logic [7:0]  upper;
      r = $random(seed);
      upper = r[8] ? exp_local : r[23:16];
      make_packet(src, {upper, r[7:0]}, int'(r[31:29]) + 1);
   endtask

   task automatic write_setting(input logic [SR_AWIDTH-1:0] addr,
                                input logic [SR_DWIDTH-1:0] data);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge clk);
      set_stb  <= 1'b0;
      @(posedge clk);
   endtask

   // One clock of input driving and output ready bursts
   task automatic step();
      logic [NUM_IN-1:0] accepted;
      logic [64:0]       w;
      logic [31:0]       r;
      @(negedge clk);
      accepted = in_tvalid & in_tready;
      @(posedge clk);
      for (int m = 0; m < NUM_IN; m++) begin
         if (!in_tvalid[m] || accepted[m]) begin
            if (drv_q[m].size() > 0) begin
               w = drv_q[m].pop_front();
               in_tdata[m*64 +: 64] <= w[63:0];
               in_tlast[m]          <= w[64];
               in_tvalid[m]         <= 1'b1;
            end else begin
               in_tvalid[m] <= 1'b0;
            end
         end
      end
      for (int o = 0; o < NUM_OUT; o++) begin
         if (burst_left[o] == 0) begin
            r = $random(seed);
            burst_left[o]  = int'(r[2:0]) + 1;
            ready_state[o] = r[4] | r[5];
         end
         burst_left[o]  = burst_left[o] - 1;
         out_tready[o] <= ready_state[o] && !hold_low[o];
      end
   endtask

   function automatic bit traffic_done(input int first_out);
      bit done;
      done = (in_tvalid == '0);
      for (int m = 0; m < NUM_IN; m++) begin
         if (drv_q[m].size() != 0) done = 1'b0;
      end
      for (int o = first_out; o < NUM_OUT; o++) begin
         for (int s = 0; s < NUM_IN; s++) begin
            if (rd_idx[o][s] != exp_q[o][s].size()) done = 1'b0;
         end
      end
      return done;
   endfunction

   task automatic run_until_done(input int first_out);
      do begin
         step();
      end while (!traffic_done(first_out));
   endtask

   initial begin : main
      logic [31:0] r;
      seed       = 32'hab48_6b1d;
      arst_n     = 1'b0;
      clear      = 1'b0;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      in_tdata   = '0;
      in_tvalid  = '0;
      in_tlast   = '0;
      out_tready = '0;
      hold_low   = '0;
      exp_local  = 8'h00;
      for (int m = 0; m < NUM_IN; m++) begin
         seq_num[m] = 16'd0;
      end
      for (int o = 0; o < NUM_OUT; o++) begin
         burst_left[o]  = 0;
         ready_state[o] = 1'b0;
      end
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      // Program the local address, then a write elsewhere
      write_setting(SR_XB_LOCAL, 32'h0000_A55A);
      exp_local = 8'h5A;
      write_setting(SR_XB_LOCAL + 16'd1, 32'h0000_00C3);
      for (int n = 0; n < N_OPEN; n++) begin
         random_packet(n % NUM_IN);
      end
      run_until_done(0);

      // Output 0 stalled, the others must still drain
      // Full-length packets on input 0 fill its output and input FIFOs exactly
      hold_low[0] = 1'b1;
      for (int n = 0; n < N_HELD; n++) begin
         r = $random(seed);
         make_packet(0, dst_for(0, r[5:0]), MAX_LEN);
      end
      for (int n = 0; n < N_SIDE; n++) begin
         r = $random(seed);
         make_packet(1, dst_for(1 + int'(r[12]), r[5:0]), int'(r[10:8]) + 1);
      end
      run_until_done(1);
      @(negedge clk);
      check_value("o_tvalid[0] while held", 64'(out_tvalid[0]), 64'd1);
      check_value("o_tready[0] while held", 64'(in_tready[0]), 64'd0);

      // Clear drops the stalled traffic
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      @(negedge clk);
      check_value("o_tvalid after clear", 64'(out_tvalid), 64'd0);
      hold_low = '0;
      @(posedge clk);

      write_setting(SR_XB_LOCAL, 32'h0000_01C3);
      exp_local = 8'hC3;
      for (int n = 0; n < N_AFTER; n++) begin
         random_packet(n % NUM_IN);
      end
      run_until_done(0);

      $display("Simulation finished: PASS");
      $finish;
   end

   // Scoreboard, packets matched to their source by the header src field
   initial begin : compare
      logic [63:0] word;
      logic        last;
      logic [64:0] exp_w;
      int          src;
      logic        in_pkt [NUM_OUT];
      int          cur_src [NUM_OUT];
      for (int o = 0; o < NUM_OUT; o++) begin
         in_pkt[o]  = 1'b0;
         cur_src[o] = 0;
         for (int s = 0; s < NUM_IN; s++) begin
            rd_idx[o][s] = 0;
         end
      end
      forever begin
         @(negedge clk);
         if (clear) begin
            for (int o = 0; o < NUM_OUT; o++) begin
               in_pkt[o] = 1'b0;
               for (int s = 0; s < NUM_IN; s++) begin
                  rd_idx[o][s] = exp_q[o][s].size();
               end
            end
         end else begin
            for (int o = 0; o < NUM_OUT; o++) begin
               if (out_tvalid[o] && out_tready[o]) begin
                  word = out_tdata[o*64 +: 64];
                  last = out_tlast[o];
                  if (!in_pkt[o]) begin
                     cur_src[o] = int'(word[47:32]);
                  end
                  src = cur_src[o];
                  if (src >= NUM_IN || rd_idx[o][src] >= exp_q[o][src].size()) begin
                     fail_now($sformatf("output %0d delivered a word nobody sent (src %0d)",
                                        o, src));
                  end
                  exp_w = exp_q[o][src][rd_idx[o][src]];
                  check_value($sformatf("o_tdata[%0d]", o), word, exp_w[63:0]);
                  check_value($sformatf("o_tlast[%0d]", o), 64'(last), 64'(exp_w[64]));
                  rd_idx[o][src] = rd_idx[o][src] + 1;
                  in_pkt[o] = !last;
               end
            end
         end
      end
   end

   initial begin : assertion_watch
      while (i_xb_subsystem_top.u_xb_checker.fail_seen !== 1'b1) @(negedge clk);
      fail_now("a bound assertion on the switch failed");
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_now($sformatf("timeout, traffic did not drain within %0d cycles",
                         WATCHDOG_CYCLES));
   end

endmodule : xb_tb

`default_nettype wire

// ==== tests/xb_checker.sv ====
// ----------------------------------------
// Bound assertions on the switch outputs and grants
// Bound to xb_subsystem_top from this file
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module xb_checker #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 3,
   parameter int IDX_W       = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
   input logic                                               i_clk,
   input logic                                               i_arst_n,
   input logic                                               i_clear,
   input logic [NUM_OUTPUTS*xb_stream_pkg::STREAM_WIDTH-1:0] i_out_tdata,
   input logic [NUM_OUTPUTS-1:0]                             i_out_tvalid,
   input logic [NUM_OUTPUTS-1:0]                             i_out_tlast,
   input logic [NUM_OUTPUTS-1:0]                             i_out_tready,
   input logic [NUM_OUTPUTS-1:0]                             i_locked,
   input logic [IDX_W-1:0]                                   i_sel [NUM_OUTPUTS]
);

   import xb_stream_pkg::*;

   // Sticky flag, watched by the testbench
   logic                   fail_seen;
   logic [NUM_OUTPUTS-1:0] held_by [NUM_INPUTS];

   always_comb begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
         for (int o = 0; o < NUM_OUTPUTS; o++) begin
            held_by[i][o] = i_locked[o] && (i_sel[o] == IDX_W'(i));
         end
      end
   end

   // Stalled output words must not change
   for (genvar g = 0; g < NUM_OUTPUTS; g++) begin : g_out
      assert property (@(posedge i_clk) disable iff (!i_arst_n)
         (i_out_tvalid[g] && !i_out_tready[g] && !i_clear) |=>
         ($stable(i_out_tdata[g*STREAM_WIDTH +: STREAM_WIDTH]) && $stable(i_out_tlast[g])))
      else begin
         $error("output %0d changed tdata or tlast while stalled", g);
         fail_seen = 1'b1;
      end
   end

   assert property (@(posedge i_clk) !i_arst_n |-> (i_out_tvalid == '0))
   else begin
      $error("an output tvalid is high during reset");
      fail_seen = 1'b1;
   end

   // One output at most per input
   for (genvar g = 0; g < NUM_INPUTS; g++) begin : g_in
      assert property (@(posedge i_clk) disable iff (!i_arst_n) $onehot0(held_by[g]))
      else begin
         $error("input %0d is granted to more than one output", g);
         fail_seen = 1'b1;
      end
   end

endmodule : xb_checker

bind xb_subsystem_top xb_checker #(
   .NUM_INPUTS  (NUM_INPUTS),
   .NUM_OUTPUTS (NUM_OUTPUTS)
) u_xb_checker (
   .i_clk        (i_clk),
   .i_arst_n     (i_arst_n),
   .i_clear      (i_clear),
   .i_out_tdata  (o_tdata),
   .i_out_tvalid (o_tvalid),
   .i_out_tlast  (o_tlast),
   .i_out_tready (i_tready),
   .i_locked     (u_axi_crossbar.locked),
   .i_sel        (u_axi_crossbar.sel)
);

`default_nettype wire

// ==== design/xb_subsystem_top.sv ====
// ----------------------------------------
// Packet switch: input FIFOs, crossbar, output FIFOs
// Local address is programmed over the settings bus
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module xb_subsystem_top #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 3
) (
   input  logic                                               i_clk,
   input  logic                                               i_arst_n,
   input  logic                                               i_clear,
   input  logic                                               i_set_stb,
   input  logic [xb_cfg_pkg::SR_AWIDTH-1:0]                   i_set_addr,
   input  logic [xb_cfg_pkg::SR_DWIDTH-1:0]                   i_set_data,
   input  logic [NUM_INPUTS*xb_stream_pkg::STREAM_WIDTH-1:0]  i_tdata,
   input  logic [NUM_INPUTS-1:0]                              i_tvalid,
   input  logic [NUM_INPUTS-1:0]                              i_tlast,
   output logic [NUM_INPUTS-1:0]                              o_tready,
   output logic [NUM_OUTPUTS*xb_stream_pkg::STREAM_WIDTH-1:0] o_tdata,
   output logic [NUM_OUTPUTS-1:0]                             o_tvalid,
   output logic [NUM_OUTPUTS-1:0]                             o_tlast,
   input  logic [NUM_OUTPUTS-1:0]                             i_tready
);

   import xb_cfg_pkg::*;
   import xb_stream_pkg::*;

   logic [LOCAL_ADDR_WIDTH-1:0]          local_addr;
   logic [NUM_INPUTS*STREAM_WIDTH-1:0]   xin_tdata;
   logic [NUM_INPUTS-1:0]                xin_tvalid;
   logic [NUM_INPUTS-1:0]                xin_tlast;
   logic [NUM_INPUTS-1:0]                xin_tready;
   logic [NUM_INPUTS-1:0]                pkt_present;
   logic [NUM_OUTPUTS*STREAM_WIDTH-1:0]  xout_tdata;
   logic [NUM_OUTPUTS-1:0]               xout_tvalid;
   logic [NUM_OUTPUTS-1:0]               xout_tlast;
   logic [NUM_OUTPUTS-1:0]               xout_tready;

   setting_reg u_sr_local_addr (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (local_addr)
   );

   // Input buffering with a packet monitor on each FIFO
   for (genvar m = 0; m < NUM_INPUTS; m++) begin : g_input
      axi_fifo_short u_fifo_in (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_clear  (i_clear),
         .i_tdata  (i_tdata[m*STREAM_WIDTH +: STREAM_WIDTH]),
         .i_tvalid (i_tvalid[m]),
         .i_tlast  (i_tlast[m]),
         .o_tready (o_tready[m]),
         .o_tdata  (xin_tdata[m*STREAM_WIDTH +: STREAM_WIDTH]),
         .o_tvalid (xin_tvalid[m]),
         .o_tlast  (xin_tlast[m]),
         .i_tready (xin_tready[m])
      );

      pkt_monitor u_mon_in (
         .i_clk           (i_clk),
         .i_arst_n        (i_arst_n),
         .i_clear         (i_clear),
         .i_in_xfer_last  (i_tvalid[m] && o_tready[m] && i_tlast[m]),
         .i_out_xfer_last (xin_tvalid[m] && xin_tready[m] && xin_tlast[m]),
         .o_pkt_present   (pkt_present[m])
      );
   end

   axi_crossbar #(
      .NUM_INPUTS  (NUM_INPUTS),
      .NUM_OUTPUTS (NUM_OUTPUTS)
   ) u_axi_crossbar (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_clear       (i_clear),
      .i_local_addr  (local_addr),
      .i_pkt_present (pkt_present),
      .i_tdata       (xin_tdata),
      .i_tvalid      (xin_tvalid),
      .i_tlast       (xin_tlast),
      .o_tready      (xin_tready),
      .o_tdata       (xout_tdata),
      .o_tvalid      (xout_tvalid),
      .o_tlast       (xout_tlast),
      .i_tready      (xout_tready)
   );

   for (genvar m = 0; m < NUM_OUTPUTS; m++) begin : g_output
      axi_fifo_short u_fifo_out (
         .i_clk    (i_clk),
         .i_arst_n (i_arst_n),
         .i_clear  (i_clear),
         .i_tdata  (xout_tdata[m*STREAM_WIDTH +: STREAM_WIDTH]),
         .i_tvalid (xout_tvalid[m]),
         .i_tlast  (xout_tlast[m]),
         .o_tready (xout_tready[m]),
         .o_tdata  (o_tdata[m*STREAM_WIDTH +: STREAM_WIDTH]),
         .o_tvalid (o_tvalid[m]),
         .o_tlast  (o_tlast[m]),
         .i_tready (i_tready[m])
      );
   end

endmodule : xb_subsystem_top

`default_nettype wire

// ==== design/axi_crossbar.sv ====
// ----------------------------------------
// Stream crossbar routing whole packets by header dst
// Round-robin per output, locked until tlast
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_crossbar #(
   parameter int NUM_INPUTS  = 2,
   parameter int NUM_OUTPUTS = 3
) (
   input  logic                                               i_clk,
   input  logic                                               i_arst_n,
   input  logic                                               i_clear,
   input  logic [xb_cfg_pkg::LOCAL_ADDR_WIDTH-1:0]            i_local_addr,
   input  logic [NUM_INPUTS-1:0]                              i_pkt_present,
   input  logic [NUM_INPUTS*xb_stream_pkg::STREAM_WIDTH-1:0]  i_tdata,
   input  logic [NUM_INPUTS-1:0]                              i_tvalid,
   input  logic [NUM_INPUTS-1:0]                              i_tlast,
   output logic [NUM_INPUTS-1:0]                              o_tready,
   output logic [NUM_OUTPUTS*xb_stream_pkg::STREAM_WIDTH-1:0] o_tdata,
   output logic [NUM_OUTPUTS-1:0]                             o_tvalid,
   output logic [NUM_OUTPUTS-1:0]                             o_tlast,
   input  logic [NUM_OUTPUTS-1:0]                             i_tready
);

   import xb_cfg_pkg::*;
   import xb_stream_pkg::*;

   localparam int IDX_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;
   localparam int OUT_W = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1;

   stream_word_u           head     [NUM_INPUTS];
   logic [OUT_W-1:0]       dest     [NUM_INPUTS];
   logic [NUM_INPUTS-1:0]  req      [NUM_OUTPUTS];
   logic [NUM_INPUTS-1:0]  grant    [NUM_OUTPUTS];
   logic [IDX_W-1:0]       sel      [NUM_OUTPUTS];
   logic [IDX_W-1:0]       pick     [NUM_OUTPUTS];
   logic [NUM_INPUTS-1:0]  in_busy;
   logic [NUM_OUTPUTS-1:0] locked;
   logic [NUM_OUTPUTS-1:0] any_req;

   // Head word decode, local match goes to low byte mod outputs
   always_comb begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
         head[i] = i_tdata[i*STREAM_WIDTH +: STREAM_WIDTH];
         if (head[i].hdr.dst[DST_WIDTH-1 -: LOCAL_ADDR_WIDTH] == i_local_addr) begin
            dest[i] = OUT_W'(head[i].hdr.dst[LOCAL_ADDR_WIDTH-1:0] % NUM_OUTPUTS);
         end else begin
            // Uplink
            dest[i] = OUT_W'(NUM_OUTPUTS - 1);
         end
      end
   end

   // Current grants, and requests from inputs not already held
   always_comb begin
      in_busy = '0;
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
         for (int i = 0; i < NUM_INPUTS; i++) begin
            grant[o][i] = locked[o] && (sel[o] == IDX_W'(i));
            in_busy[i]  = in_busy[i] | grant[o][i];
         end
      end
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
         for (int i = 0; i < NUM_INPUTS; i++) begin
            req[o][i] = i_pkt_present[i] && i_tvalid[i] && !in_busy[i] &&
                        (dest[i] == OUT_W'(o));
         end
      end
   end

   // Round-robin search starting just after the previous winner
   always_comb begin : rr_pick
      int idx;
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
         any_req[o] = 1'b0;
         pick[o]    = sel[o];
         for (int k = 1; k <= NUM_INPUTS; k++) begin
            idx = (int'(sel[o]) + k) % NUM_INPUTS;
            if (!any_req[o] && req[o][idx]) begin
               any_req[o] = 1'b1;
               pick[o]    = IDX_W'(idx);
            end
         end
      end
   end

   // Steering mux, data words go through the raw view
   always_comb begin
      o_tready = '0;
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
         o_tdata[o*STREAM_WIDTH +: STREAM_WIDTH] = head[sel[o]].data;
         o_tvalid[o] = locked[o] && i_tvalid[sel[o]];
         o_tlast[o]  = i_tlast[sel[o]];
         for (int i = 0; i < NUM_INPUTS; i++) begin
            o_tready[i] = o_tready[i] | (grant[o][i] && i_tready[o]);
         end
      end
   end

   // Lock on grant, release once tlast is accepted
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         locked <= '0;
         for (int o = 0; o < NUM_OUTPUTS; o++) begin
            sel[o] <= '0;
         end
      end else if (i_clear) begin
         locked <= '0;
      end else begin
         for (int o = 0; o < NUM_OUTPUTS; o++) begin
            if (!locked[o]) begin
               if (any_req[o]) begin
                  locked[o] <= 1'b1;
                  sel[o]    <= pick[o];
               end
            end else if (o_tvalid[o] && i_tready[o] && o_tlast[o]) begin
               locked[o] <= 1'b0;
            end
         end
      end
   end

endmodule : axi_crossbar

`default_nettype wire

// ==== design/pkt_monitor.sv ====
// ----------------------------------------
// Whole-packet counter beside an input FIFO
// Tells the crossbar a complete packet is waiting
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pkt_monitor (
   input  logic i_clk,
   input  logic i_arst_n,
   input  logic i_clear,
   input  logic i_in_xfer_last,
   input  logic i_out_xfer_last,
   output logic o_pkt_present
);

   import xb_stream_pkg::*;

   // A full FIFO can hold one single-word packet per entry
   logic [FIFO_DEPTH_LOG2:0] pkt_count;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pkt_count <= '0;
      end else if (i_clear) begin
         pkt_count <= '0;
      end else if (i_in_xfer_last && !i_out_xfer_last) begin
         pkt_count <= pkt_count + 1'b1;
      end else if (!i_in_xfer_last && i_out_xfer_last) begin
         pkt_count <= pkt_count - 1'b1;
      end
   end

   assign o_pkt_present = (pkt_count != '0);

endmodule : pkt_monitor

`default_nettype wire

// ==== design/axi_fifo_short.sv ====
// ----------------------------------------
// Short stream FIFO carrying data plus last
// Used on every crossbar input and output
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_fifo_short (
   input  logic                                   i_clk,
   input  logic                                   i_arst_n,
   input  logic                                   i_clear,
   input  logic [xb_stream_pkg::STREAM_WIDTH-1:0] i_tdata,
   input  logic                                   i_tvalid,
   input  logic                                   i_tlast,
   output logic                                   o_tready,
   output logic [xb_stream_pkg::STREAM_WIDTH-1:0] o_tdata,
   output logic                                   o_tvalid,
   output logic                                   o_tlast,
   input  logic                                   i_tready
);

   import xb_stream_pkg::*;

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   logic [STREAM_WIDTH:0]      mem [DEPTH];
   logic [FIFO_DEPTH_LOG2:0]   wr_ptr;
   logic [FIFO_DEPTH_LOG2:0]   rd_ptr;
   logic                       empty;
   logic                       full;
   logic                       wr_en;
   logic                       rd_en;

   // Wrap bit differs and index equal means full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                  (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

   assign wr_en    = i_tvalid && !full;
   assign rd_en    = i_tready && !empty;
   assign o_tready = !full;
   assign o_tvalid = !empty;

   // Head entry is read straight out of the array
   assign {o_tlast, o_tdata} = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

   always_ff @(posedge i_clk) begin
      if (wr_en) begin
         mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= {i_tlast, i_tdata};
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else if (i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule : axi_fifo_short

`default_nettype wire

// ==== design/setting_reg.sv ====
// ----------------------------------------
// Local address register on the settings bus
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module setting_reg (
   input  logic                                   i_clk,
   input  logic                                   i_arst_n,
   input  logic                                   i_set_stb,
   input  logic [xb_cfg_pkg::SR_AWIDTH-1:0]       i_set_addr,
   input  logic [xb_cfg_pkg::SR_DWIDTH-1:0]       i_set_data,
   output logic [xb_cfg_pkg::LOCAL_ADDR_WIDTH-1:0] o_value
);

   import xb_cfg_pkg::*;

   // Only the low bits of the data word are kept
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_value <= '0;
      end else if (i_set_stb && (i_set_addr == SR_XB_LOCAL)) begin
         o_value <= i_set_data[LOCAL_ADDR_WIDTH-1:0];
      end
   end

endmodule : setting_reg

`default_nettype wire

// ==== design/xb_stream_pkg.sv ====
// ----------------------------------------
// Stream word layout shared by FIFOs and crossbar
// First word of a packet is a header, the rest are raw data
// ----------------------------------------
`default_nettype none

package xb_stream_pkg;

   localparam int unsigned STREAM_WIDTH    = 64;
   localparam int unsigned DST_WIDTH       = 16;
   localparam int unsigned FIFO_DEPTH_LOG2 = 4;

   // Header word fields, dst in the top bits
   typedef struct packed {
      logic [DST_WIDTH-1:0] dst;
      logic [15:0]          src;
      logic [15:0]          seq;
      logic [15:0]          len;
   } stream_hdr_t;

   // Same 64 bits seen as a header or as plain payload
   typedef union packed {
      stream_hdr_t               hdr;
      logic [STREAM_WIDTH-1:0]   data;
   } stream_word_u;

endpackage : xb_stream_pkg

`default_nettype wire

// ==== design/xb_cfg_pkg.sv ====
// ----------------------------------------
// Settings bus widths and register map
// Imported by the settings register and the crossbar
// ----------------------------------------
`default_nettype none

package xb_cfg_pkg;

   // Settings bus shape
   localparam int unsigned SR_AWIDTH = 16;
   localparam int unsigned SR_DWIDTH = 32;

   // Register map
   localparam logic [SR_AWIDTH-1:0] SR_XB_LOCAL = 16'd512;

   // Local address compared against the upper destination byte
   localparam int unsigned LOCAL_ADDR_WIDTH = 8;

endpackage : xb_cfg_pkg

`default_nettype wire
